/* rtl/ctiqPkg.sv */
// Queue sizes are fixed here and QueueDepth must stay a power of two so that IDs wrap on their own
package ctiqPkg;

	// Lanes per fetch bundle and per commit group
	localparam int FetchWidth = 4;
	localparam int CommitWidth = 2;

	// Entry count of the CTI queue
	localparam int QueueDepth = 16;
	localparam int CtiIdWidth = $clog2(QueueDepth);

	// Branch payload fields
	localparam int PcWidth = 32;
	localparam int BranchTypeWidth = 2;

	// Queue index, also handed out as the CTI ID
	typedef logic [CtiIdWidth-1:0] ctiId_t;

	// One extra bit so that a completely full queue can be counted
	typedef logic [CtiIdWidth:0] ctiCount_t;

	typedef logic [PcWidth-1:0] pc_t;

	typedef logic [BranchTypeWidth-1:0] branchType_t;

	// Two-bit saturating counter from the direction predictor
	typedef logic [1:0] predCounter_t;

endpackage

/* rtl/ctiPayloadRam.sv */
// Flop array with a combinational read and no read-during-write bypass, so a write shows a cycle later
`timescale 1ns/1ps

module ctiPayloadRam #(
	parameter int Width      = 1,
	parameter int WritePorts = 1
) (
	input  logic                         clk,
	input  logic                         reset,

	input  ctiqPkg::ctiId_t              readAddr_i,
	output logic [Width-1:0]             readData_o,

	input  ctiqPkg::ctiId_t              writeAddr_i [WritePorts],
	input  logic [Width-1:0]             writeData_i [WritePorts],
	input  logic [WritePorts-1:0]        writeEn_i
);

	import ctiqPkg::*;

	logic [Width-1:0] mem [QueueDepth];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Cleared so an idle head reads defined data
			for (int e = 0; e < QueueDepth; e++)
			begin
				mem[e] <= '0;
			end
		end
		else
		begin
			// Later ports overwrite earlier ones on the same address
			for (int p = 0; p < WritePorts; p++)
			begin
				if (writeEn_i[p])
				begin
					mem[writeAddr_i[p]] <= writeData_i[p];
				end
			end
		end
	end

	assign readData_o = mem[readAddr_i];

endmodule

/* rtl/ctiTagAllocator.sv */
// IDs of a refused bundle carry no meaning and fetch must present the same bundle again
`timescale 1ns/1ps

module ctiTagAllocator (
	input  logic                                 clk,
	input  logic                                 reset,

	input  logic                                 fs1Ready_i,
	input  logic                                 stall_i,
	input  logic                                 recover_i,
	input  logic                                 exception_i,

	input  logic [ctiqPkg::FetchWidth-1:0]       ctrlVect_i,
	input  logic                                 queueFull_i,
	input  ctiqPkg::ctiId_t                      commitPtrNext_i,

	output ctiqPkg::ctiId_t                      ctiId_o [ctiqPkg::FetchWidth],
	output logic [ctiqPkg::FetchWidth-1:0]       laneWrite_o,
	output ctiqPkg::ctiCount_t                   ctrlCount_o,
	output ctiqPkg::ctiCount_t                   pushCount_o
);

	import ctiqPkg::*;

	// Next free entry, owned by the youngest allocated branch plus one
	ctiId_t tailPtr;

	logic accept;

	// Prefix count over the lanes gives each branch its offset from the tail
	always_comb
	begin
		ctiCount_t lanesBelow;

		lanesBelow = '0;
		for (int i = 0; i < FetchWidth; i++)
		begin
			if (ctrlVect_i[i])
			begin
				ctiId_o[i] = tailPtr + lanesBelow[CtiIdWidth-1:0];
			end
			else
			begin
				ctiId_o[i] = '0;
			end
			lanesBelow = lanesBelow + ctiCount_t'(ctrlVect_i[i]);
		end
		ctrlCount_o = lanesBelow;
	end

	// Whole bundle goes in or none of it does
	assign accept = fs1Ready_i & ~stall_i & ~queueFull_i;

	assign laneWrite_o = accept ? ctrlVect_i : '0;
	assign pushCount_o = accept ? ctrlCount_o : '0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tailPtr <= '0;
		end
		else if (recover_i || exception_i)
		begin
			// Squash everything younger than the commit point
			tailPtr <= commitPtrNext_i;
		end
		else
		begin
			tailPtr <= tailPtr + pushCount_o[CtiIdWidth-1:0];
		end
	end

endmodule

/* rtl/ctiCommitTracker.sv */
// Commit lanes are counted, so commitCti_i is expected to be packed from lane 0 upward
`timescale 1ns/1ps

module ctiCommitTracker (
	input  logic                                 clk,
	input  logic                                 reset,

	input  logic                                 exception_i,
	input  logic [ctiqPkg::CommitWidth-1:0]      commitCti_i,

	input  ctiqPkg::ctiId_t                      headPtr_i,
	input  logic                                 popEn_i,

	output ctiqPkg::ctiId_t                      commitPtrNext_o,
	output logic                                 headCommitted_o
);

	import ctiqPkg::*;

	// Oldest entry that has not committed yet
	ctiId_t commitPtr;

	logic [QueueDepth-1:0] committed;
	logic [QueueDepth-1:0] committedNext;

	ctiCount_t commitCount;

	always_comb
	begin
		commitCount = '0;
		for (int i = 0; i < CommitWidth; i++)
		begin
			commitCount = commitCount + ctiCount_t'(commitCti_i[i]);
		end
	end

	assign commitPtrNext_o = commitPtr + commitCount[CtiIdWidth-1:0];

	always_comb
	begin
		ctiId_t slot;

		committedNext = committed;

		// Entry leaves the queue once it has been sent to the predictor
		if (popEn_i)
		begin
			committedNext[headPtr_i] = 1'b0;
		end

		// New commits are set last so they win over a clear
		for (int i = 0; i < CommitWidth; i++)
		begin
			slot = commitPtr + ctiId_t'(i);
			if (ctiCount_t'(i) < commitCount)
			begin
				committedNext[slot] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			commitPtr <= '0;
			committed <= '0;
		end
		else
		begin
			commitPtr <= commitPtrNext_o;
			if (exception_i)
			begin
				committed <= '0;
			end
			else
			begin
				committed <= committedNext;
			end
		end
	end

	assign headCommitted_o = committed[headPtr_i];

endmodule

/* rtl/ctiUpdateSequencer.sv */
// At most one predictor update per cycle and updates stop whenever recover_i is high
`timescale 1ns/1ps

module ctiUpdateSequencer (
	input  logic                                 clk,
	input  logic                                 reset,

	input  logic                                 recover_i,
	input  logic                                 exception_i,

	input  ctiqPkg::ctiCount_t                   ctrlCount_i,
	input  ctiqPkg::ctiCount_t                   pushCount_i,
	input  logic [ctiqPkg::FetchWidth-1:0]       laneWrite_i,
	input  ctiqPkg::ctiId_t                      ctiId_i [ctiqPkg::FetchWidth],
	input  ctiqPkg::predCounter_t                predCounter_i [ctiqPkg::FetchWidth],

	input  ctiqPkg::ctiId_t                      exeCtiId_i,
	input  ctiqPkg::pc_t                         exePc_i,
	input  ctiqPkg::pc_t                         exeNpc_i,
	input  ctiqPkg::branchType_t                 exeType_i,
	input  logic                                 exeDir_i,
	input  logic                                 exeValid_i,

	input  ctiqPkg::ctiId_t                      commitPtrNext_i,
	input  logic                                 headCommitted_i,

	output ctiqPkg::ctiId_t                      headPtr_o,
	output logic                                 popEn_o,
	output logic                                 queueFull_o,

	output ctiqPkg::pc_t                         updatePc_o,
	output ctiqPkg::pc_t                         updateNpc_o,
	output ctiqPkg::branchType_t                 updateType_o,
	output logic                                 updateDir_o,
	output ctiqPkg::predCounter_t                updateCounter_o
);

	import ctiqPkg::*;

	ctiCount_t occupancy;
	ctiId_t    headNext;

	// Resolved branch record as stored per entry
	logic [2*PcWidth+BranchTypeWidth:0] exeWord [1];
	logic [2*PcWidth+BranchTypeWidth:0] headWord;
	ctiId_t                             exeAddr [1];

	// Head entry goes out once it is committed and nothing is being squashed
	assign popEn_o = headCommitted_i & (occupancy != '0) & ~recover_i;

	assign queueFull_o = ctrlCount_i > (ctiCount_t'(QueueDepth) - occupancy);

	assign headNext = headPtr_o + ctiId_t'(popEn_o);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			headPtr_o <= '0;
			occupancy <= '0;
		end
		else
		begin
			headPtr_o <= headNext;
			if (recover_i || exception_i)
			begin
				// Only entries up to the commit point survive a squash
				occupancy <= {1'b0, commitPtrNext_i - headNext};
			end
			else
			begin
				occupancy <= occupancy + pushCount_i - ctiCount_t'(popEn_o);
			end
		end
	end

	assign exeAddr[0] = exeCtiId_i;
	assign exeWord[0] = {exePc_i, exeNpc_i, exeType_i, exeDir_i};

	// Execute results, one writer from the branch pipe
	ctiPayloadRam #(
		.Width      ($bits(headWord)),
		.WritePorts (1)
	) exeRam (
		.clk         (clk),
		.reset       (reset),
		.readAddr_i  (headPtr_o),
		.readData_o  (headWord),
		.writeAddr_i (exeAddr),
		.writeData_i (exeWord),
		.writeEn_i   (exeValid_i)
	);

	assign {updatePc_o, updateNpc_o, updateType_o, updateDir_o} = headWord;

	// Prediction counters, captured per accepted lane at allocation
	ctiPayloadRam #(
		.Width      ($bits(predCounter_t)),
		.WritePorts (FetchWidth)
	) counterRam (
		.clk         (clk),
		.reset       (reset),
		.readAddr_i  (headPtr_o),
		.readData_o  (updateCounter_o),
		.writeAddr_i (ctiId_i),
		.writeData_i (predCounter_i),
		.writeEn_i   (laneWrite_i)
	);

endmodule

/* rtl/ctiQueue.sv */
// Plain strobes with no handshake, and fetch must hold a refused bundle while fullFlag_o or stall_i is high
`timescale 1ns/1ps

module ctiQueue (
	input  logic                                 clk,
	input  logic                                 reset,

	input  logic                                 stall_i,
	input  logic                                 recover_i,
	input  logic                                 exception_i,
	input  logic                                 fs1Ready_i,

	input  logic [ctiqPkg::FetchWidth-1:0]       ctrlVect_i,
	input  ctiqPkg::predCounter_t                predCounter_i [ctiqPkg::FetchWidth],
	output ctiqPkg::ctiId_t                      ctiId_o [ctiqPkg::FetchWidth],

	input  ctiqPkg::ctiId_t                      exeCtiId_i,
	input  ctiqPkg::pc_t                         exePc_i,
	input  ctiqPkg::pc_t                         exeNpc_i,
	input  ctiqPkg::branchType_t                 exeType_i,
	input  logic                                 exeDir_i,
	input  logic                                 exeValid_i,

	input  logic [ctiqPkg::CommitWidth-1:0]      commitCti_i,

	output ctiqPkg::pc_t                         updatePc_o,
	output ctiqPkg::pc_t                         updateNpc_o,
	output ctiqPkg::branchType_t                 updateType_o,
	output logic                                 updateDir_o,
	output ctiqPkg::predCounter_t                updateCounter_o,
	output logic                                 updateEn_o,

	output logic                                 fullFlag_o
);

	import ctiqPkg::*;

	ctiCount_t                 ctrlCount;
	ctiCount_t                 pushCount;
	logic [FetchWidth-1:0]     laneWrite;
	ctiId_t                    commitPtrNext;
	ctiId_t                    headPtr;
	logic                      headCommitted;

	// Tail side
	ctiTagAllocator tagAllocator (
		.clk             (clk),
		.reset           (reset),
		.fs1Ready_i      (fs1Ready_i),
		.stall_i         (stall_i),
		.recover_i       (recover_i),
		.exception_i     (exception_i),
		.ctrlVect_i      (ctrlVect_i),
		.queueFull_i     (fullFlag_o),
		.commitPtrNext_i (commitPtrNext),
		.ctiId_o         (ctiId_o),
		.laneWrite_o     (laneWrite),
		.ctrlCount_o     (ctrlCount),
		.pushCount_o     (pushCount)
	);

	// Commit side
	ctiCommitTracker commitTracker (
		.clk             (clk),
		.reset           (reset),
		.exception_i     (exception_i),
		.commitCti_i     (commitCti_i),
		.headPtr_i       (headPtr),
		.popEn_i         (updateEn_o),
		.commitPtrNext_o (commitPtrNext),
		.headCommitted_o (headCommitted)
	);

	ctiUpdateSequencer updateSequencer (
		.clk             (clk),
		.reset           (reset),
		.recover_i       (recover_i),
		.exception_i     (exception_i),
		.ctrlCount_i     (ctrlCount),
		.pushCount_i     (pushCount),
		.laneWrite_i     (laneWrite),
		.ctiId_i         (ctiId_o),
		.predCounter_i   (predCounter_i),
		.exeCtiId_i      (exeCtiId_i),
		.exePc_i         (exePc_i),
		.exeNpc_i        (exeNpc_i),
		.exeType_i       (exeType_i),
		.exeDir_i        (exeDir_i),
		.exeValid_i      (exeValid_i),
		.commitPtrNext_i (commitPtrNext),
		.headCommitted_i (headCommitted),
		.headPtr_o       (headPtr),
		.popEn_o         (updateEn_o),
		.queueFull_o     (fullFlag_o),
		.updatePc_o      (updatePc_o),
		.updateNpc_o     (updateNpc_o),
		.updateType_o    (updateType_o),
		.updateDir_o     (updateDir_o),
		.updateCounter_o (updateCounter_o)
	);

endmodule

/* testbench/ctiClockGen.sv */
// Free-running clock with a 4 ns period and reset held high for the first five rising edges
`timescale 1ns/1ps

module ctiClockGen (
	output logic clk_o,
	output logic reset_o
);

	localparam int HalfPeriod  = 2;
	localparam int ResetCycles = 5;

	initial
	begin
		clk_o = 1'b0;
		forever #HalfPeriod clk_o = ~clk_o;
	end

	initial
	begin
		reset_o = 1'b1;
		repeat (ResetCycles) @(posedge clk_o);
		// Release away from the rising edge
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

/* testbench/ctiQueueTb.sv */
// Outputs are checked on the falling edge and exceptions are raised only with an empty update backlog
`timescale 1ns/1ps

module ctiQueueTb;

	import ctiqPkg::*;

	localparam int FillCycles    = 40;
	localparam int MixCycles     = 400;
	localparam int RecoverCycles = 300;
	localparam int ExceptCycles  = 300;
	localparam int DrainCycles   = 60;
	localparam int CycleLimit    =
		2 * (FillCycles + MixCycles + RecoverCycles + ExceptCycles + DrainCycles);

	int seed = 32'h75a8;

	logic                   clk;
	logic                   reset;
	logic                   stall_i, recover_i, exception_i, fs1Ready_i;
	logic [FetchWidth-1:0]  ctrlVect_i;
	predCounter_t           predCounter_i [FetchWidth];
	ctiId_t                 ctiId_o [FetchWidth];
	ctiId_t                 exeCtiId_i;
	pc_t                    exePc_i, exeNpc_i;
	branchType_t            exeType_i;
	logic                   exeDir_i, exeValid_i;
	logic [CommitWidth-1:0] commitCti_i;
	pc_t                    updatePc_o, updateNpc_o;
	branchType_t            updateType_o;
	logic                   updateDir_o;
	predCounter_t           updateCounter_o;
	logic                   updateEn_o, fullFlag_o;

	// Reference model state
	ctiId_t                     mTail, mCommit, mHead;
	int                         mOcc, mPending, mResolved;
	logic [QueueDepth-1:0]      mCommitted;
	pc_t                        mPc [QueueDepth];
	pc_t                        mNpc [QueueDepth];
	logic [BranchTypeWidth:0]   mTypeDir [QueueDepth];
	predCounter_t               mCnt [QueueDepth];

	// Expected values for this cycle and model state after the coming edge
	int                              bundleCnt, commitCnt, pushCnt;
	int                              backlogNext, pendingNext, resolvedNext;
	logic                            expFull, expAccept, expUpdate, squash;
	ctiId_t                          commitNext, headNext;
	logic [QueueDepth-1:0]           committedNext;
	logic [FetchWidth*CtiIdWidth-1:0] expIdBits, dutIdBits;

	int cycleCount = 0;
	int fullSeen = 0;
	int updateCount = 0;
	int recoverCount = 0;
	int exceptCount = 0;
	bit queueEmpty = 1'b0;

	ctiClockGen clockGen (.clk_o(clk), .reset_o(reset));

	ctiQueue ctiQueue_i (.*);

	always_comb
	begin
		bundleCnt = 0;
		for (int i = 0; i < FetchWidth; i++)
		begin
			// Each branch takes the tail plus the branches in lower lanes
			expIdBits[i*CtiIdWidth +: CtiIdWidth] =
				ctrlVect_i[i] ? ctiId_t'(int'(mTail) + bundleCnt) : '0;
			dutIdBits[i*CtiIdWidth +: CtiIdWidth] = ctiId_o[i];
			bundleCnt += ctrlVect_i[i] ? 1 : 0;
		end
		commitCnt = 0;
		for (int i = 0; i < CommitWidth; i++)
			commitCnt += commitCti_i[i] ? 1 : 0;
		expFull = bundleCnt > QueueDepth - mOcc;
		expAccept = fs1Ready_i && !stall_i && !expFull;
		pushCnt = expAccept ? bundleCnt : 0;
		expUpdate = mCommitted[mHead] && mOcc != 0 && !recover_i;
		squash = recover_i || exception_i;
		commitNext = ctiId_t'(int'(mCommit) + commitCnt);
		headNext = ctiId_t'(int'(mHead) + (expUpdate ? 1 : 0));
		committedNext = mCommitted;
		if (expUpdate)
			committedNext[mHead] = 1'b0;
		for (int i = 0; i < CommitWidth; i++)
			if (i < commitCnt)
				committedNext[ctiId_t'(int'(mCommit) + i)] = 1'b1;
		if (exception_i)
			committedNext = '0;
		backlogNext = $countones(committedNext);
		pendingNext = squash ? 0 : mPending + pushCnt - commitCnt;
		resolvedNext = squash ? 0 : mResolved + (exeValid_i ? 1 : 0) - commitCnt;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mTail <= '0;
			mCommit <= '0;
			mHead <= '0;
			mOcc <= 0;
			mPending <= 0;
			mResolved <= 0;
			mCommitted <= '0;
		end
		else
		begin
			mTail <= squash ? commitNext : ctiId_t'(int'(mTail) + pushCnt);
			mCommit <= commitNext;
			mHead <= headNext;
			// Only entries up to the commit point survive a squash
			mOcc <= squash ? int'(ctiId_t'(commitNext - headNext))
				: mOcc + pushCnt - (expUpdate ? 1 : 0);
			mCommitted <= committedNext;
			mPending <= pendingNext;
			mResolved <= resolvedNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (exeValid_i)
		begin
			mPc[exeCtiId_i] <= exePc_i;
			mNpc[exeCtiId_i] <= exeNpc_i;
			mTypeDir[exeCtiId_i] <= {exeType_i, exeDir_i};
		end
		for (int i = 0; i < FetchWidth; i++)
			if (expAccept && ctrlVect_i[i])
				mCnt[expIdBits[i*CtiIdWidth +: CtiIdWidth]] <= predCounter_i[i];
	end

	task automatic failCheck(input string what);
		$display("[FAIL] time %0t: %s", $time, what);
		$display("*** FAILED ***");
		$fatal(1, "DUT output differs from the reference model");
	endtask

	// The expected update is low in every recovery cycle
	assert property (@(negedge clk) disable iff (reset) updateEn_o == expUpdate)
		else failCheck("updateEn_o does not match the committed head state");
	assert property (@(negedge clk) disable iff (reset) fullFlag_o == expFull)
		else failCheck("fullFlag_o does not match the model occupancy");
	assert property (@(negedge clk) disable iff (reset) !expAccept || dutIdBits == expIdBits)
		else failCheck("CTI IDs of an accepted bundle are wrong");
	assert property (@(negedge clk) disable iff (reset)
		!expUpdate || (updatePc_o == mPc[mHead] && updateNpc_o == mNpc[mHead]
		&& {updateType_o, updateDir_o} == mTypeDir[mHead]))
		else failCheck("update payload differs from the execute data of the head ID");
	assert property (@(negedge clk) disable iff (reset)
		!expUpdate || updateCounter_o == mCnt[mHead])
		else failCheck("update counter differs from the counter given at allocation");

	always @(negedge clk)
	begin
		if (!reset)
		begin
			cycleCount++;
			if (expFull && fs1Ready_i)
				fullSeen++;
			if (updateEn_o)
				updateCount++;
			if (cycleCount >= CycleLimit)
			begin
				$display("Timeout: the run passed %0d cycles without finishing", CycleLimit);
				$display("*** FAILED ***");
				$fatal(1, "timeout");
			end
		end
	end

	// Inputs for the next cycle are chosen from the model state after the coming edge
	task automatic driveCycle(input bit fetchOn, input bit commitOn, input int recoverOdds,
		input int exceptOdds);
		bit hold;
		bit rec;
		bit exc;
		bit exeGo;
		ctiId_t exeId;
		int nCommit;

		@(negedge clk);
		queueEmpty = (mOcc == 0) && (mPending == 0);
		// A refused bundle is presented again unchanged
		hold = fetchOn && fs1Ready_i && !expAccept && !squash;
		nCommit = commitOn ? int'($unsigned($random(seed)) % 3) : 0;
		if (nCommit > resolvedNext)
			nCommit = resolvedNext;
		if (backlogNext + nCommit > QueueDepth - 1)
			nCommit = QueueDepth - 1 - backlogNext;
		rec = recoverOdds > 0 && ($unsigned($random(seed)) % recoverOdds) == 0;
		exc = !rec && exceptOdds > 0 && backlogNext == 0
			&& ($unsigned($random(seed)) % exceptOdds) == 0;
		if (exc)
			nCommit = 0;
		exeGo = resolvedNext < pendingNext;
		exeId = ctiId_t'(int'(commitNext) + resolvedNext);
		if (rec)
			recoverCount++;
		if (exc)
			exceptCount++;

		@(posedge clk);
		if (!hold)
		begin
			ctrlVect_i <= FetchWidth'($random(seed));
			for (int i = 0; i < FetchWidth; i++)
				predCounter_i[i] <= predCounter_t'($random(seed));
		end
		fs1Ready_i <= fetchOn && (hold || ($random(seed) & 7) != 0);
		stall_i <= ($random(seed) & 7) == 0;
		recover_i <= rec;
		exception_i <= exc;
		commitCti_i <= CommitWidth'((1 << nCommit) - 1);
		exeValid_i <= exeGo;
		exeCtiId_i <= exeId;
		exePc_i <= pc_t'($random(seed));
		exeNpc_i <= pc_t'($random(seed));
		exeType_i <= branchType_t'($random(seed));
		exeDir_i <= 1'($random(seed));
	endtask

	initial
	begin
		stall_i = 1'b0;
		recover_i = 1'b0;
		exception_i = 1'b0;
		fs1Ready_i = 1'b0;
		ctrlVect_i = '0;
		for (int i = 0; i < FetchWidth; i++)
			predCounter_i[i] = '0;
		exeCtiId_i = '0;
		exePc_i = '0;
		exeNpc_i = '0;
		exeType_i = '0;
		exeDir_i = 1'b0;
		exeValid_i = 1'b0;
		commitCti_i = '0;

		@(negedge reset);
		// No commits at first so the queue runs full
		repeat (FillCycles) driveCycle(1'b1, 1'b0, 0, 0);
		repeat (MixCycles) driveCycle(1'b1, 1'b1, 0, 0);
		repeat (RecoverCycles) driveCycle(1'b1, 1'b1, 12, 0);
		repeat (ExceptCycles) driveCycle(1'b1, 1'b1, 0, 6);
		queueEmpty = 1'b0;
		while (!queueEmpty)
			driveCycle(1'b0, 1'b1, 0, 0);

		@(negedge clk);
		if (fullSeen == 0 || updateCount == 0 || recoverCount == 0 || exceptCount == 0)
		begin
			$display("Stimulus missed a behavior: full %0d, updates %0d, recoveries %0d",
				fullSeen, updateCount, recoverCount);
			$display("Exceptions issued: %0d", exceptCount);
			$display("*** FAILED ***");
			$fatal(1, "incomplete stimulus");
		end
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* verilog.f */
rtl/ctiqPkg.sv
rtl/ctiPayloadRam.sv
rtl/ctiTagAllocator.sv
rtl/ctiCommitTracker.sv
rtl/ctiUpdateSequencer.sv
rtl/ctiQueue.sv
testbench/ctiClockGen.sv
testbench/ctiQueueTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ctiQueueTb \
	-f verilog.f -o simCtiQueue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simCtiQueue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
